// ==== compile.f ====
verilog/calc_pkg.sv
verilog/calc_ctrl.sv
verilog/calc_operand_stage.sv
verilog/calc_pipe_int.sv
verilog/calc_pipe_mul.sv
verilog/calc_pipe_long.sv
verilog/calc_comp_pipe.sv
verilog/calc_top.sv
test/tb_clk_gen.sv
test/tb_calc_top.sv

// ==== test/tb_calc_top.sv ====
// Calculator testbench
`timescale 1ns/10ps

module tb_calc_top
  import calc_pkg::*;
();

  logic      clk;
  logic      arst_n;
  logic      dispatch_v;
  calc_op_e  dispatch_op;
  reg_addr_t dispatch_rd;
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  word_t     rs1_data;
  word_t     rs2_data;
  logic      dispatch_ready;
  logic      iwb_v;
  reg_addr_t iwb_rd;
  word_t     iwb_data;
  logic      div_busy;

  // Committed registers feed dispatch and the issue-order copy gives the expected values
  word_t       arch_rf [32];
  word_t       spec_rf [32];
  int          mul_cyc [32];
  int          exp_cyc_q [$];
  reg_addr_t   exp_rd_q [$];
  word_t       exp_data_q [$];
  logic        div_active;
  logic        div_busy_exp;
  logic        div_seen;
  reg_addr_t   div_rd;
  word_t       div_res;
  int          div_acc_cyc;
  int          cyc;
  int unsigned seed;
  logic        acc;
  calc_op_e    op;
  reg_addr_t   rd;
  reg_addr_t   rs1;
  reg_addr_t   rs2;

  tb_clk_gen u_clk_gen
  (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  calc_top #(.data_width_p(32)) u_dut
  (
    .clk_i               (clk),
    .arst_n_i            (arst_n),
    .dispatch_v_i        (dispatch_v),
    .dispatch_op_i       (dispatch_op),
    .dispatch_rd_i       (dispatch_rd),
    .dispatch_rs1_addr_i (rs1_addr),
    .dispatch_rs2_addr_i (rs2_addr),
    .dispatch_rs1_data_i (rs1_data),
    .dispatch_rs2_data_i (rs2_data),
    .dispatch_ready_o    (dispatch_ready),
    .iwb_v_o             (iwb_v),
    .iwb_rd_o            (iwb_rd),
    .iwb_data_o          (iwb_data),
    .div_busy_o          (div_busy)
  );

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1, "run stopped");
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
      report_failure($sformatf("Error: %s got 0x%h, expected 0x%h", name, got, exp));
  endtask

  function automatic word_t model_result(input calc_op_e o, input word_t a, input word_t b);
    case (o)
      op_add:  return a + b;
      op_sub:  return a - b;
      op_and:  return a & b;
      op_xor:  return a ^ b;
      op_sll:  return a << b[4:0];
      op_mul:  return a * b;
      default: return (b == 0) ? '1 : a / b;
    endcase
  endfunction

  function automatic logic reg_free(input reg_addr_t r, input logic is_src);
    if (div_active && r == div_rd)
      return 1'b0;
    // Multiply result reaches the bypass three edges after its accept
    return !is_src || (cyc + 1 - mul_cyc[r] >= 3);
  endfunction

  task automatic pick_instr(input int unsigned n_ops, output calc_op_e o, output reg_addr_t d,
                            output reg_addr_t s1, output reg_addr_t s2);
    o = calc_op_e'($urandom % n_ops);
    // Small register window keeps dependent chains frequent
    do d = reg_addr_t'($urandom % 8); while (!reg_free(d, 1'b0));
    do s1 = reg_addr_t'($urandom % 8); while (!reg_free(s1, 1'b1));
    do s2 = reg_addr_t'($urandom % 8); while (!reg_free(s2, 1'b1));
  endtask

  // Writeback seen in this cycle lands at the next rising edge
  task automatic check_outputs();
    check_val("div_busy_o", div_busy, div_busy_exp);
    if (exp_cyc_q.size() != 0 && exp_cyc_q[0] == cyc + 1)
    begin
      check_val("iwb_v_o", iwb_v, 1'b1);
      check_val("iwb_rd_o", iwb_rd, exp_rd_q[0]);
      check_val("iwb_data_o", iwb_data, exp_data_q[0]);
      arch_rf[exp_rd_q[0]] = exp_data_q[0];
      void'(exp_cyc_q.pop_front());
      void'(exp_rd_q.pop_front());
      void'(exp_data_q.pop_front());
    end
    else if (iwb_v)
    begin
      if (!div_active)
        report_failure("Writeback seen with no instruction pending");
      check_val("iwb_rd_o", iwb_rd, div_rd);
      check_val("iwb_data_o", iwb_data, div_res);
      if (cyc + 1 - div_acc_cyc < div_cycles_lp)
        report_failure("Divide result came back sooner than its iteration count");
      arch_rf[div_rd] = div_res;
      div_active = 1'b0;
      div_seen   = 1'b1;
    end
  endtask

  task automatic run_cycle(input logic v, input calc_op_e o, input reg_addr_t d,
                           input reg_addr_t s1, input reg_addr_t s2, output logic accepted);
    word_t res;
    @(negedge clk);
    dispatch_v  = v;
    dispatch_op = o;
    dispatch_rd = d;
    rs1_addr    = s1;
    rs2_addr    = s2;
    rs1_data    = arch_rf[s1];
    rs2_data    = arch_rf[s2];
    check_outputs();
    #1;
    accepted = v && dispatch_ready;
    check_val("dispatch_ready_o", dispatch_ready, !(div_busy_exp && o == op_divu));
    @(posedge clk);
    cyc++;
    if (div_seen)
    begin
      div_busy_exp = 1'b0;
      div_seen     = 1'b0;
    end
    if (accepted)
    begin
      res        = model_result(o, spec_rf[s1], spec_rf[s2]);
      spec_rf[d] = res;
      if (o == op_divu)
      begin
        div_active   = 1'b1;
        div_busy_exp = 1'b1;
        div_rd       = d;
        div_res      = res;
        div_acc_cyc  = cyc;
      end
      else
      begin
        exp_cyc_q.push_back(cyc + 4);
        exp_rd_q.push_back(d);
        exp_data_q.push_back(res);
        if (o == op_mul)
          mul_cyc[d] = cyc;
      end
    end
  endtask

  task automatic wait_reset();
    int n;
    n = 0;
    while (!arst_n)
    begin
      @(posedge clk);
      n++;
      if (n > 20)
        report_failure("Timeout waiting for reset release");
    end
  endtask

  task automatic wait_div();
    int n;
    logic a;
    n = 0;
    while (div_active)
    begin
      run_cycle(1'b0, op_add, 5'd0, 5'd0, 5'd0, a);
      n++;
      if (n > 100)
        report_failure("Timeout waiting for the divide writeback");
    end
  endtask

  task automatic drain_pipe();
    int n;
    logic a;
    n = 0;
    while (exp_cyc_q.size() != 0 || div_busy_exp)
    begin
      run_cycle(1'b0, op_add, 5'd0, 5'd0, 5'd0, a);
      n++;
      if (n > 200)
        report_failure("Timeout waiting for the pipe to drain");
    end
  endtask

  initial
  begin
    seed        = 4368;
    void'($urandom(seed));
    dispatch_v  = 1'b0;
    dispatch_op = op_add;
    dispatch_rd = '0;
    rs1_addr    = '0;
    rs2_addr    = '0;
    rs1_data    = '0;
    rs2_data    = '0;
    div_active   = 1'b0;
    div_busy_exp = 1'b0;
    div_seen     = 1'b0;
    div_rd       = '0;
    div_res      = '0;
    div_acc_cyc  = 0;
    cyc          = 0;
    for (int i = 0; i < 32; i++)
    begin
      arch_rf[i] = $urandom;
      spec_rf[i] = arch_rf[i];
      mul_cyc[i] = -8;
    end

    wait_reset();
    @(negedge clk);
    check_val("iwb_v_o", iwb_v, 1'b0);
    check_val("div_busy_o", div_busy, 1'b0);
    check_val("dispatch_ready_o", dispatch_ready, 1'b1);

    // Zero divisor, then a second divide that must be refused
    run_cycle(1'b1, op_xor, 5'd20, 5'd21, 5'd21, acc);
    run_cycle(1'b1, op_divu, 5'd22, 5'd21, 5'd20, acc);
    run_cycle(1'b1, op_divu, 5'd23, 5'd21, 5'd21, acc);
    wait_div();

    // Divide finishing under a dense integer stream
    drain_pipe();
    run_cycle(1'b1, op_divu, 5'd24, 5'd25, 5'd26, acc);
    for (int i = 0; i < 40; i++)
    begin
      pick_instr(5, op, rd, rs1, rs2);
      run_cycle(1'b1, op, rd, rs1, rs2, acc);
    end
    wait_div();

    drain_pipe();
    for (int i = 0; i < 400; i++)
    begin
      pick_instr(7, op, rd, rs1, rs2);
      run_cycle(($urandom % 4) != 0, op, rd, rs1, rs2, acc);
    end
    drain_pipe();

    $display("Done: no errors");
    $finish;
  end

endmodule

// ==== test/tb_clk_gen.sv ====
// Testbench clock and reset
`timescale 1ns/10ps

module tb_clk_gen
#(
  parameter int half_period_p  = 50,
  parameter int reset_cycles_p = 8
)
(
  output logic clk_o,
  output logic arst_n_o
);

  initial
  begin
    clk_o = 1'b0;
    forever #(half_period_p) clk_o = ~clk_o;
  end

  // Release away from the rising edge
  initial
  begin
    arst_n_o = 1'b0;
    repeat (reset_cycles_p) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

// ==== verilog/calc_top.sv ====
// Integer execution calculator
`timescale 1ns/10ps

module calc_top
  import calc_pkg::*;
#(
  parameter int data_width_p = $bits(word_t)
)
(
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      dispatch_v_i,
  input  calc_op_e                  dispatch_op_i,
  input  reg_addr_t                 dispatch_rd_i,
  input  reg_addr_t                 dispatch_rs1_addr_i,
  input  reg_addr_t                 dispatch_rs2_addr_i,
  input  logic [data_width_p-1:0]   dispatch_rs1_data_i,
  input  logic [data_width_p-1:0]   dispatch_rs2_data_i,
  output logic                      dispatch_ready_o,
  output logic                      iwb_v_o,
  output reg_addr_t                 iwb_rd_o,
  output logic [data_width_p-1:0]   iwb_data_o,
  output logic                      div_busy_o
);

  logic                                        res_v;
  calc_op_e                                    res_op;
  logic      [comp_stages_lp-1:0]              stage_wv;
  reg_addr_t [comp_stages_lp-1:0]              stage_rd;
  logic      [comp_stages_lp-1:0][data_width_p-1:0] fwd_data;
  logic      [data_width_p-1:0]                res_rs1;
  logic      [data_width_p-1:0]                res_rs2;
  logic                                        int_v;
  logic      [data_width_p-1:0]                int_data;
  logic                                        mul_v;
  logic      [data_width_p-1:0]                mul_data;
  logic                                        div_start;
  logic                                        div_grant;
  logic                                        div_done;
  logic      [data_width_p-1:0]                div_data;

  calc_ctrl u_ctrl
  (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .dispatch_v_i     (dispatch_v_i),
    .dispatch_op_i    (dispatch_op_i),
    .dispatch_rd_i    (dispatch_rd_i),
    .div_done_i       (div_done),
    .div_busy_i       (div_busy_o),
    .dispatch_ready_o (dispatch_ready_o),
    .res_v_o          (res_v),
    .res_op_o         (res_op),
    .stage_wv_o       (stage_wv),
    .stage_rd_o       (stage_rd),
    .div_start_o      (div_start),
    .div_grant_o      (div_grant),
    .iwb_v_o          (iwb_v_o),
    .iwb_rd_o         (iwb_rd_o)
  );

  calc_operand_stage #(.data_width_p(data_width_p)) u_operand_stage
  (
    .clk_i               (clk_i),
    .dispatch_rs1_addr_i (dispatch_rs1_addr_i),
    .dispatch_rs2_addr_i (dispatch_rs2_addr_i),
    .dispatch_rs1_data_i (dispatch_rs1_data_i),
    .dispatch_rs2_data_i (dispatch_rs2_data_i),
    .stage_wv_i          (stage_wv),
    .stage_rd_i          (stage_rd),
    .fwd_data_i          (fwd_data),
    .res_rs1_o           (res_rs1),
    .res_rs2_o           (res_rs2)
  );

  calc_pipe_int #(.data_width_p(data_width_p)) u_pipe_int
  (
    .res_op_i   (res_op),
    .res_rs1_i  (res_rs1),
    .res_rs2_i  (res_rs2),
    .int_v_o    (int_v),
    .int_data_o (int_data)
  );

  calc_pipe_mul #(.data_width_p(data_width_p)) u_pipe_mul
  (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .res_v_i    (res_v),
    .res_op_i   (res_op),
    .res_rs1_i  (res_rs1),
    .res_rs2_i  (res_rs2),
    .mul_v_o    (mul_v),
    .mul_data_o (mul_data)
  );

  calc_pipe_long #(.data_width_p(data_width_p)) u_pipe_long
  (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .div_start_i (div_start),
    .res_rs1_i   (res_rs1),
    .res_rs2_i   (res_rs2),
    .div_grant_i (div_grant),
    .div_busy_o  (div_busy_o),
    .div_done_o  (div_done),
    .div_data_o  (div_data)
  );

  calc_comp_pipe #(.data_width_p(data_width_p)) u_comp_pipe
  (
    .clk_i       (clk_i),
    .int_v_i     (int_v),
    .int_data_i  (int_data),
    .mul_v_i     (mul_v),
    .mul_data_i  (mul_data),
    .div_grant_i (div_grant),
    .div_data_i  (div_data),
    .fwd_data_o  (fwd_data),
    .iwb_data_o  (iwb_data_o)
  );

endmodule

// ==== verilog/calc_comp_pipe.sv ====
// Completion data pipe
`timescale 1ns/10ps

module calc_comp_pipe
  import calc_pkg::*;
#(
  parameter int data_width_p = 32
)
(
  input  logic                                          clk_i,
  input  logic                                          int_v_i,
  input  logic [data_width_p-1:0]                       int_data_i,
  input  logic                                          mul_v_i,
  input  logic [data_width_p-1:0]                       mul_data_i,
  input  logic                                          div_grant_i,
  input  logic [data_width_p-1:0]                       div_data_i,
  output logic [comp_stages_lp-1:0][data_width_p-1:0]   fwd_data_o,
  output logic [data_width_p-1:0]                       iwb_data_o
);

  localparam int last_lp = comp_stages_lp - 1;

  // Stage 0 is the reservation and carries no result yet
  logic [data_width_p-1:0] stage_n [1:last_lp];
  logic [data_width_p-1:0] stage_r [1:last_lp];

  always_comb
  begin
    stage_n[1] = int_v_i ? int_data_i : '0;
    for (int i = 2; i <= last_lp; i++)
      stage_n[i] = stage_r[i-1];
    if (mul_v_i)
      stage_n[mul_stage_lp] = mul_data_i;
  end

  always_ff @(posedge clk_i)
  begin
    for (int i = 1; i <= last_lp; i++)
      stage_r[i] <= stage_n[i];
  end

  // Each stage forwards what it hands to the next one
  always_comb
  begin
    for (int i = 0; i < last_lp; i++)
      fwd_data_o[i] = stage_n[i+1];
    fwd_data_o[last_lp] = stage_r[last_lp];
  end

  assign iwb_data_o = div_grant_i ? div_data_i : stage_r[last_lp];

endmodule

// ==== verilog/calc_pipe_long.sv ====
// Iterative unsigned divider
`timescale 1ns/10ps

module calc_pipe_long
#(
  parameter int data_width_p = 32
)
(
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      div_start_i,
  input  logic [data_width_p-1:0]   res_rs1_i,
  input  logic [data_width_p-1:0]   res_rs2_i,
  input  logic                      div_grant_i,
  output logic                      div_busy_o,
  output logic                      div_done_o,
  output logic [data_width_p-1:0]   div_data_o
);

  localparam int div_cycles    = data_width_p;
  localparam int cnt_width_lp  = $clog2(div_cycles);

  typedef enum logic [1:0] {div_idle, div_run, div_hold} div_state_e;

  div_state_e              state_r;
  logic [cnt_width_lp-1:0] cnt_r;
  logic [data_width_p-1:0] rem_r;
  logic [data_width_p-1:0] quo_r;
  logic [data_width_p-1:0] dsr_r;
  logic [data_width_p:0]   rem_sh;
  logic [data_width_p:0]   diff;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_r <= div_idle;
      cnt_r   <= '0;
    end
    else
    begin
      case (state_r)
        div_idle:
          if (div_start_i)
          begin
            state_r <= div_run;
            cnt_r   <= '0;
          end
        div_run:
        begin
          cnt_r <= cnt_r + 1'b1;
          if (cnt_r == cnt_width_lp'(div_cycles - 1))
            state_r <= div_hold;
        end
        // Result waits here for a free writeback slot
        default:
          if (div_grant_i)
            state_r <= div_idle;
      endcase
    end
  end

  // One quotient bit per cycle, shift then trial subtract
  assign rem_sh = {rem_r, quo_r[data_width_p-1]};
  assign diff   = rem_sh - {1'b0, dsr_r};

  always_ff @(posedge clk_i)
  begin
    if (state_r == div_idle && div_start_i)
    begin
      rem_r <= '0;
      quo_r <= res_rs1_i;
      dsr_r <= res_rs2_i;
    end
    else if (state_r == div_run)
    begin
      rem_r <= diff[data_width_p] ? rem_sh[data_width_p-1:0] : diff[data_width_p-1:0];
      quo_r <= {quo_r[data_width_p-2:0], ~diff[data_width_p]};
    end
  end

  // A zero divisor never borrows, so every quotient bit comes out set
  assign div_busy_o = (state_r != div_idle) | div_start_i;
  assign div_done_o = (state_r == div_hold);
  assign div_data_o = quo_r;

endmodule

// ==== verilog/calc_pipe_mul.sv ====
// Two stage multiply pipe
`timescale 1ns/10ps

module calc_pipe_mul
  import calc_pkg::*;
#(
  parameter int data_width_p = 32
)
(
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      res_v_i,
  input  calc_op_e                  res_op_i,
  input  logic [data_width_p-1:0]   res_rs1_i,
  input  logic [data_width_p-1:0]   res_rs2_i,
  output logic                      mul_v_o,
  output logic [data_width_p-1:0]   mul_data_o
);

  logic                    opd_v_r;
  logic [data_width_p-1:0] opd_a_r;
  logic [data_width_p-1:0] opd_b_r;
  logic                    prod_v_r;
  logic [data_width_p-1:0] prod_r;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      opd_v_r  <= 1'b0;
      prod_v_r <= 1'b0;
    end
    else
    begin
      opd_v_r  <= res_v_i & (res_op_i == op_mul);
      prod_v_r <= opd_v_r;
    end
  end

  // Low half only, the product is truncated to the result width
  always_ff @(posedge clk_i)
  begin
    opd_a_r <= res_rs1_i;
    opd_b_r <= res_rs2_i;
    prod_r  <= opd_a_r * opd_b_r;
  end

  assign mul_v_o    = prod_v_r;
  assign mul_data_o = prod_r;

endmodule

// ==== verilog/calc_pipe_int.sv ====
// Single cycle integer ALU
`timescale 1ns/10ps

module calc_pipe_int
  import calc_pkg::*;
#(
  parameter int data_width_p = 32
)
(
  input  calc_op_e                  res_op_i,
  input  logic [data_width_p-1:0]   res_rs1_i,
  input  logic [data_width_p-1:0]   res_rs2_i,
  output logic                      int_v_o,
  output logic [data_width_p-1:0]   int_data_o
);

  localparam int shamt_width_lp = $clog2(data_width_p);

  logic [shamt_width_lp-1:0] shamt;

  assign shamt = res_rs2_i[shamt_width_lp-1:0];

  always_comb
  begin
    int_v_o = 1'b1;
    case (res_op_i)
      op_add:  int_data_o = res_rs1_i + res_rs2_i;
      op_sub:  int_data_o = res_rs1_i - res_rs2_i;
      op_and:  int_data_o = res_rs1_i & res_rs2_i;
      op_xor:  int_data_o = res_rs1_i ^ res_rs2_i;
      op_sll:  int_data_o = res_rs1_i << shamt;
      default:
      begin
        // Multiply and divide belong to the other pipes
        int_v_o    = 1'b0;
        int_data_o = '0;
      end
    endcase
  end

endmodule

// ==== verilog/calc_operand_stage.sv ====
// Operand bypass and reservation
`timescale 1ns/10ps

module calc_operand_stage
  import calc_pkg::*;
#(
  parameter int data_width_p = 32
)
(
  input  logic                                         clk_i,
  input  reg_addr_t                                    dispatch_rs1_addr_i,
  input  reg_addr_t                                    dispatch_rs2_addr_i,
  input  logic      [data_width_p-1:0]                 dispatch_rs1_data_i,
  input  logic      [data_width_p-1:0]                 dispatch_rs2_data_i,
  input  logic      [comp_stages_lp-1:0]               stage_wv_i,
  input  reg_addr_t [comp_stages_lp-1:0]               stage_rd_i,
  input  logic      [comp_stages_lp-1:0][data_width_p-1:0] fwd_data_i,
  output logic      [data_width_p-1:0]                 res_rs1_o,
  output logic      [data_width_p-1:0]                 res_rs2_o
);

  logic [data_width_p-1:0] rs1_n;
  logic [data_width_p-1:0] rs2_n;

  // Walk from oldest to youngest so the youngest match wins
  always_comb
  begin
    rs1_n = dispatch_rs1_data_i;
    rs2_n = dispatch_rs2_data_i;
    for (int i = comp_stages_lp - 1; i >= 0; i--)
    begin
      if (stage_wv_i[i] && stage_rd_i[i] == dispatch_rs1_addr_i)
        rs1_n = fwd_data_i[i];
      if (stage_wv_i[i] && stage_rd_i[i] == dispatch_rs2_addr_i)
        rs2_n = fwd_data_i[i];
    end
  end

  always_ff @(posedge clk_i)
  begin
    res_rs1_o <= rs1_n;
    res_rs2_o <= rs2_n;
  end

endmodule

// ==== verilog/calc_ctrl.sv ====
// Issue and completion control
`timescale 1ns/10ps

module calc_ctrl
  import calc_pkg::*;
(
  input  logic                                 clk_i,
  input  logic                                 arst_n_i,
  input  logic                                 dispatch_v_i,
  input  calc_op_e                             dispatch_op_i,
  input  reg_addr_t                            dispatch_rd_i,
  input  logic                                 div_done_i,
  input  logic                                 div_busy_i,
  output logic                                 dispatch_ready_o,
  output logic                                 res_v_o,
  output calc_op_e                             res_op_o,
  output logic      [comp_stages_lp-1:0]       stage_wv_o,
  output reg_addr_t [comp_stages_lp-1:0]       stage_rd_o,
  output logic                                 div_start_o,
  output logic                                 div_grant_o,
  output logic                                 iwb_v_o,
  output reg_addr_t                            iwb_rd_o
);

  localparam int last_lp = comp_stages_lp - 1;

  logic                                 accept;
  logic      [comp_stages_lp-1:0]       stage_v_r;
  logic      [comp_stages_lp-1:0]       stage_we_r;
  reg_addr_t [comp_stages_lp-1:0]       stage_rd_r;
  calc_op_e                             res_op_r;
  reg_addr_t                            div_rd_r;

  // Only a second divide is held off, other ops always issue
  assign dispatch_ready_o = ~(div_busy_i & (dispatch_op_i == op_divu));
  assign accept           = dispatch_v_i & dispatch_ready_o;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      stage_v_r <= '0;
      res_op_r  <= op_add;
    end
    else
    begin
      stage_v_r <= {stage_v_r[last_lp-1:0], accept};
      if (accept)
        res_op_r <= dispatch_op_i;
    end
  end

  // Divides write back later through the grant
  always_ff @(posedge clk_i)
  begin
    stage_we_r    <= {stage_we_r[last_lp-1:0], dispatch_op_i != op_divu};
    stage_rd_r[0] <= dispatch_rd_i;
    for (int i = 1; i < comp_stages_lp; i++)
      stage_rd_r[i] <= stage_rd_r[i-1];
    if (accept && dispatch_op_i == op_divu)
      div_rd_r <= dispatch_rd_i;
  end

  assign stage_wv_o  = stage_v_r & stage_we_r;
  assign stage_rd_o  = stage_rd_r;
  assign res_v_o     = stage_v_r[0];
  assign res_op_o    = res_op_r;
  assign div_start_o = stage_v_r[0] & (res_op_r == op_divu);

  // Divide result takes the writeback slot only when the static pipe leaves it empty
  assign div_grant_o = div_done_i & ~stage_wv_o[last_lp];
  assign iwb_v_o     = stage_wv_o[last_lp] | div_grant_o;
  assign iwb_rd_o    = div_grant_o ? div_rd_r : stage_rd_r[last_lp];

endmodule

// ==== verilog/calc_pkg.sv ====
// Calculator shared definitions
package calc_pkg;

  localparam int word_width_lp = 32;

  // Operand and result data
  typedef logic [word_width_lp-1:0] word_t;

  // Register file address
  typedef logic [4:0] reg_addr_t;

  typedef enum logic [2:0]
  {
    op_add  = 3'd0,
    op_sub  = 3'd1,
    op_and  = 3'd2,
    op_xor  = 3'd3,
    op_sll  = 3'd4,
    op_mul  = 3'd5,
    op_divu = 3'd6
  } calc_op_e;

  // Stage 0 is the reservation, the last stage is writeback
  localparam int comp_stages_lp = 4;

  // Stage that the multiply result is written into
  localparam int mul_stage_lp = 3;

  // Iterations of the divider at the default width
  localparam int div_cycles_lp = word_width_lp;

endpackage
